// ==== files.f ====
verilog/tile_mem_pkg.sv
verilog/torus_noc_pkg.sv
verilog/link_input_fifo.sv
verilog/torus_route_ctrl.sv
verilog/tile_dmem_endpoint.sv
verilog/compute_tile.sv
sim/tb_clock_gen.sv
sim/compute_tile_tb.sv

// ==== sim/compute_tile_tb.sv ====
`timescale 1ns/10ps
// directed testbench for one compute tile placed at x 1, y 2
// neighbors are modeled by credit counters and receive queues
// only E and S can carry traffic out of this tile
module compute_tile_tb;
  import tile_mem_pkg::*;
  import torus_noc_pkg::*;

  localparam int timeout_lp = 200;

  logic                       clk;
  logic                       reset;
  logic                       tile_reset;
  link_s [dir_s:dir_w]        link_i;
  link_s [dir_s:dir_w]        link_o;
  logic [dir_s:dir_w]         link_credit_i;
  logic [dir_s:dir_w]         link_credit_o;
  logic [x_cord_width_lp-1:0] global_x_i;
  logic [y_cord_width_lp-1:0] global_y_i;
  logic [x_cord_width_lp-1:0] global_x_o;
  logic [y_cord_width_lp-1:0] global_y_o;
  int                         in_credits [num_dirs_lp];
  int                         owed [num_dirs_lp];
  logic                       withhold [num_dirs_lp];
  link_flit_s                 rx_e [$];
  link_flit_s                 rx_s [$];

  tb_clock_gen clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  compute_tile uut (
    .clk_i         (clk),
    .reset_i       (reset),
    .reset_o       (tile_reset),
    .link_i        (link_i),
    .link_o        (link_o),
    .link_credit_i (link_credit_i),
    .link_credit_o (link_credit_o),
    .global_x_i    (global_x_i),
    .global_y_i    (global_y_i),
    .global_x_o    (global_x_o),
    .global_y_o    (global_y_o)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flit(input string test, input link_flit_s exp, input link_flit_s act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_coord(input string test, input logic [y_cord_width_lp-1:0] exp,
                             input logic [y_cord_width_lp-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s: expected %0d, actual %0d", test, exp, act));
    end
  endtask

  task automatic check_bits(input string test, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s: expected %b, actual %b", test, exp, act));
    end
  endtask

  // sender position of all test traffic is 0,2
  function automatic link_flit_s make_flit(input mem_op_e op, input logic [1:0] dx,
                                           input logic [1:0] dy, input logic [7:0] addr,
                                           input logic [31:0] data);
    link_flit_s f;
    f = '{opcode: op, dst_x: dx, dst_y: dy, src_x: 2'd0, src_y: 2'd2, addr: addr, data: data};
    return f;
  endfunction

  // one clock, inputs change 2 ns after the edge
  task automatic step();
    @(posedge clk);
    #2;
    for (int d = dir_w; d <= dir_s; d++) begin
      link_i[d].v = 1'b0;
    end
  endtask

  task automatic wait_credit(input int d, input string what);
    int n = 0;
    while (in_credits[d] == 0) begin
      if (n == timeout_lp) fail_now($sformatf("no input credit on port %0d for %s", d, what));
      step();
      n++;
    end
  endtask

  task automatic drive_flit(input int d, input link_flit_s f);
    link_i[d] = '{v: 1'b1, flit: f};
    in_credits[d]--;
  endtask

  task automatic send_flit(input int d, input link_flit_s f, input string what);
    wait_credit(d, what);
    drive_flit(d, f);
    step();
  endtask

  task automatic take_rx(input int d, input string what, output link_flit_s f);
    int n = 0;
    while ((d == dir_e) ? (rx_e.size() == 0) : (rx_s.size() == 0)) begin
      if (n == timeout_lp) fail_now($sformatf("%s never appeared on output %0d", what, d));
      step();
      n++;
    end
    if (d == dir_e) f = rx_e.pop_front();
    else f = rx_s.pop_front();
  endtask

  task automatic wait_credits_full(input int d, input string what);
    int n = 0;
    while (in_credits[d] != link_fifo_els_lp) begin
      if (n == timeout_lp) fail_now($sformatf("%s: input credit never came back", what));
      step();
      n++;
    end
  endtask

  // neighbor model, samples 1 ns after the edge, returns credits at 2 ns
  always begin
    logic [dir_s:dir_w] ret;
    @(posedge clk);
    #1;
    if (link_o[dir_w].v === 1'b1 || link_o[dir_n].v === 1'b1) begin
      fail_now("a flit left on W or N, which the router never routes to");
    end
    if (link_o[dir_e].v === 1'b1) begin
      rx_e.push_back(link_o[dir_e].flit);
      owed[dir_e]++;
    end
    if (link_o[dir_s].v === 1'b1) begin
      rx_s.push_back(link_o[dir_s].flit);
      owed[dir_s]++;
    end
    for (int d = dir_w; d <= dir_s; d++) begin
      if (link_credit_o[d] === 1'b1) begin
        if (in_credits[d] >= link_fifo_els_lp) fail_now("input credit returned past buffer depth");
        in_credits[d]++;
      end
      ret[d] = !withhold[d] && (owed[d] > 0);
      if (ret[d]) owed[d]--;
    end
    #1;
    link_credit_i = ret;
  end

  task automatic reset_coords();
    int n = 0;
    while (tile_reset !== 1'b1) begin
      if (n == timeout_lp) fail_now("reset_o never followed reset_i high");
      step();
      n++;
    end
    while (tile_reset !== 1'b0) begin
      if (n == timeout_lp) fail_now("reset_o never followed reset_i low");
      step();
      n++;
    end
    check_bits("reset_coords valid",
               4'b0, {link_o[dir_s].v, link_o[dir_n].v, link_o[dir_e].v, link_o[dir_w].v});
    check_bits("reset_coords credit", 4'b0, link_credit_o);
    check_coord("reset_coords x", 2'd1, global_x_o);
    check_coord("reset_coords y", 2'd3, global_y_o);
    global_y_i = 2'd3;
    step();
    // bottom row wraps to 0
    check_coord("reset_coords y wrap", 2'd0, global_y_o);
    global_y_i = 2'd2;
    step();
  endtask

  task automatic route_pass();
    link_flit_s fw;
    link_flit_s fn;
    link_flit_s got;
    fw = make_flit(op_store, 2'd3, 2'd2, 8'($urandom), $urandom);
    fn = make_flit(op_load, 2'd1, 2'd0, 8'($urandom), $urandom);
    send_flit(dir_w, fw, "route_pass W flit");
    send_flit(dir_n, fn, "route_pass N flit");
    take_rx(dir_e, "route_pass W flit", got);
    check_flit("route_pass W to E", fw, got);
    take_rx(dir_s, "route_pass N flit", got);
    check_flit("route_pass N to S", fn, got);
    wait_credits_full(dir_w, "route_pass W");
    wait_credits_full(dir_n, "route_pass N");
  endtask

  task automatic mem_store_load();
    logic [dmem_addr_width_lp-1:0] addr [4];
    logic [dmem_data_width_lp-1:0] data [4];
    link_flit_s got;
    link_flit_s exp;
    for (int i = 0; i < 4; i++) begin
      addr[i] = {2'(i), 6'($urandom)};
      data[i] = $urandom;
      send_flit(dir_w, make_flit(op_store, 2'd1, 2'd2, addr[i], data[i]), "mem store");
    end
    for (int i = 0; i < 4; i++) begin
      send_flit(dir_w, make_flit(op_load, 2'd1, 2'd2, addr[i], '0), "mem load");
    end
    for (int i = 0; i < 4; i++) begin
      take_rx(dir_e, "load response", got);
      exp = make_flit(op_resp, 2'd0, 2'd2, addr[i], data[i]);
      exp.src_x = 2'd1;
      exp.src_y = 2'd2;
      check_flit("mem_store_load", exp, got);
    end
  endtask

  task automatic backpressure();
    link_flit_s f [3];
    link_flit_s got;
    int n = 0;
    withhold[dir_e] = 1'b1;
    for (int i = 0; i < 3; i++) begin
      f[i] = make_flit(op_store, 2'd3, 2'd1, 8'(i), $urandom);
      send_flit(dir_w, f[i], "backpressure flit");
    end
    while (rx_e.size() < 2) begin
      if (n == timeout_lp) fail_now("backpressure: first two flits never appeared on E");
      step();
      n++;
    end
    repeat (10) step();
    if (rx_e.size() != 2) fail_now("backpressure: a flit left on E without a credit");
    withhold[dir_e] = 1'b0;
    for (int i = 0; i < 3; i++) begin
      take_rx(dir_e, "backpressure flit", got);
      check_flit("backpressure order", f[i], got);
    end
  endtask

  task automatic contention();
    link_flit_s fa;
    link_flit_s fb;
    link_flit_s got;
    logic seen_a = 1'b0;
    logic seen_b = 1'b0;
    fa = make_flit(op_store, 2'd3, 2'd0, 8'h11, $urandom);
    fb = make_flit(op_store, 2'd3, 2'd3, 8'h22, ~fa.data);
    wait_credit(dir_w, "contention W flit");
    wait_credit(dir_n, "contention N flit");
    drive_flit(dir_w, fa);
    drive_flit(dir_n, fb);
    step();
    repeat (2) begin
      take_rx(dir_e, "contention flit", got);
      if (got === fa && !seen_a) seen_a = 1'b1;
      else if (got === fb && !seen_b) seen_b = 1'b1;
      else fail_now($sformatf("[FAIL] contention: expected %h or %h, actual %h", fa, fb, got));
    end
    repeat (5) step();
    if (rx_e.size() != 0) fail_now("contention: a flit appeared on E more than once");
  endtask

  initial begin
    void'($urandom(32'h93e1));
    link_i        = '0;
    link_credit_i = '0;
    global_x_i    = 2'd1;
    global_y_i    = 2'd2;
    for (int d = 0; d < num_dirs_lp; d++) begin
      in_credits[d] = link_fifo_els_lp;
      owed[d]       = 0;
      withhold[d]   = 1'b0;
    end
    reset_coords();
    route_pass();
    mem_store_load();
    backpressure();
    contention();
    $display("TB PASSED");
    $finish;
  end
endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps
// free running 20 ns clock
// reset high through the first two rising edges
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end
endmodule

// ==== verilog/compute_tile.sv ====
`timescale 1ns/10ps
// one tile of a 4x4 torus, router plus memory endpoint
// links are indexed W..S with the router port numbering
// reset and coordinates are registered here
// everything inside runs on the registered reset
// x passes through, y goes out incremented for the tile below
module compute_tile (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  output logic                                      reset_o,
  input  torus_noc_pkg::link_s [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] link_i,
  output torus_noc_pkg::link_s [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] link_o,
  input  logic [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] link_credit_i,
  output logic [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] link_credit_o,
  input  logic [torus_noc_pkg::x_cord_width_lp-1:0] global_x_i,
  input  logic [torus_noc_pkg::y_cord_width_lp-1:0] global_y_i,
  output logic [torus_noc_pkg::x_cord_width_lp-1:0] global_x_o,
  output logic [torus_noc_pkg::y_cord_width_lp-1:0] global_y_o
);
  import torus_noc_pkg::*;

  logic                         reset_r;
  logic [x_cord_width_lp-1:0]   my_x_r;
  logic [y_cord_width_lp-1:0]   my_y_r;
  link_flit_s [dir_s:dir_w]     head;
  logic [dir_s:dir_w]           head_v;
  logic [dir_s:dir_w]           pop;
  link_s [num_dirs_lp-1:0]      rtr_out;
  logic [num_dirs_lp-1:0]       rtr_credit;
  link_s                        ep_resp;
  logic                         ep_resp_credit;
  logic                         ep_req_credit;

  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
    my_x_r  <= global_x_i;
    my_y_r  <= global_y_i;
  end

  assign reset_o    = reset_r;
  assign global_x_o = my_x_r;
  // wrap at the bottom row of the torus
  assign global_y_o = (my_y_r == y_cord_width_lp'(num_tiles_y_lp - 1)) ? '0 : my_y_r + 1'b1;

  for (genvar d = dir_w; d <= dir_s; d++) begin : g_in
    link_input_fifo in_fifo (
      .clk_i    (clk_i),
      .reset_i  (reset_r),
      .link_i   (link_i[d]),
      .pop_i    (pop[d]),
      .head_o   (head[d]),
      .head_v_o (head_v[d]),
      .credit_o (link_credit_o[d])
    );
  end

  // P credit comes from the endpoint request buffer
  assign rtr_credit = {link_credit_i, ep_req_credit};
  assign link_o     = rtr_out[dir_s:dir_w];

  torus_route_ctrl rtr (
    .clk_i         (clk_i),
    .reset_i       (reset_r),
    .my_x_i        (my_x_r),
    .my_y_i        (my_y_r),
    .head_i        (head),
    .head_v_i      (head_v),
    .pop_o         (pop),
    .out_o         (rtr_out),
    .credit_i      (rtr_credit),
    .proc_link_i   (ep_resp),
    .proc_credit_o (ep_resp_credit)
  );

  tile_dmem_endpoint ep (
    .clk_i         (clk_i),
    .reset_i       (reset_r),
    .my_x_i        (my_x_r),
    .my_y_i        (my_y_r),
    .req_i         (rtr_out[dir_p]),
    .req_credit_o  (ep_req_credit),
    .resp_o        (ep_resp),
    .resp_credit_i (ep_resp_credit)
  );

endmodule

// ==== verilog/link_input_fifo.sv ====
`timescale 1ns/10ps
// input buffer for one credit-based link
// writes are not checked for overflow, the sender's credits guarantee room
// one credit pulse per pop, registered, so it lands the cycle after
module link_input_fifo (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  torus_noc_pkg::link_s      link_i,
  input  logic                      pop_i,
  output torus_noc_pkg::link_flit_s head_o,
  output logic                      head_v_o,
  output logic                      credit_o
);
  import torus_noc_pkg::*;

  link_flit_s                     mem_r [link_fifo_els_lp];
  logic [link_ptr_width_lp-1:0]   wptr_r;
  logic [link_ptr_width_lp-1:0]   rptr_r;
  logic [credit_cnt_width_lp-1:0] count_r;
  logic                           do_pop;

  assign head_o   = mem_r[rptr_r];
  assign head_v_o = (count_r != '0);
  assign do_pop   = pop_i && head_v_o;

  // storage
  always_ff @(posedge clk_i) begin
    if (link_i.v) begin
      mem_r[wptr_r] <= link_i.flit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r   <= '0;
      rptr_r   <= '0;
      count_r  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (link_i.v) wptr_r <= wptr_r + 1'b1;
      if (do_pop) rptr_r <= rptr_r + 1'b1;
      case ({link_i.v, do_pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      credit_o <= do_pop;
    end
  end

endmodule

// ==== verilog/tile_dmem_endpoint.sv ====
`timescale 1ns/10ps
// memory endpoint on router port P
// services remote loads and stores, one request per cycle at most
// holds a single response slot, a request waits while it is full
// incoming response packets are dropped
module tile_dmem_endpoint (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [torus_noc_pkg::x_cord_width_lp-1:0] my_x_i,
  input  logic [torus_noc_pkg::y_cord_width_lp-1:0] my_y_i,
  input  torus_noc_pkg::link_s                      req_i,
  output logic                                      req_credit_o,
  output torus_noc_pkg::link_s                      resp_o,
  input  logic                                      resp_credit_i
);
  import tile_mem_pkg::*;
  import torus_noc_pkg::*;

  link_flit_s                     req_head;
  logic                           req_head_v;
  logic                           req_pop;
  logic                           is_load;
  logic                           is_store;
  logic                           resp_send;
  logic                           resp_pend_r;
  link_flit_s                     resp_flit_r;
  logic [credit_cnt_width_lp-1:0] credit_cnt_r;
  logic [dmem_data_width_lp-1:0]  mem_r [dmem_els_lp];

  link_input_fifo req_fifo (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .link_i   (req_i),
    .pop_i    (req_pop),
    .head_o   (req_head),
    .head_v_o (req_head_v),
    .credit_o (req_credit_o)
  );

  // response goes out as soon as a credit is available
  assign resp_send = resp_pend_r && (credit_cnt_r != '0);
  assign req_pop   = req_head_v && (!resp_pend_r || resp_send);
  assign is_load   = req_pop && (req_head.opcode == op_load);
  assign is_store  = req_pop && (req_head.opcode == op_store);
  assign resp_o    = '{v: resp_send, flit: resp_flit_r};

  // memory with synchronous read into the response slot
  always_ff @(posedge clk_i) begin
    if (is_store) begin
      mem_r[req_head.addr] <= req_head.data;
    end
    if (is_load) begin
      resp_flit_r.opcode <= op_resp;
      resp_flit_r.dst_x  <= req_head.src_x;
      resp_flit_r.dst_y  <= req_head.src_y;
      resp_flit_r.src_x  <= my_x_i;
      resp_flit_r.src_y  <= my_y_i;
      resp_flit_r.addr   <= req_head.addr;
      resp_flit_r.data   <= mem_r[req_head.addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_pend_r  <= 1'b0;
      credit_cnt_r <= credit_cnt_width_lp'(link_fifo_els_lp);
    end else begin
      if (is_load) begin
        resp_pend_r <= 1'b1;
      end else if (resp_send) begin
        resp_pend_r <= 1'b0;
      end
      case ({resp_send, resp_credit_i})
        2'b10:   credit_cnt_r <= credit_cnt_r - 1'b1;
        2'b01:   credit_cnt_r <= credit_cnt_r + 1'b1;
        default: credit_cnt_r <= credit_cnt_r;
      endcase
    end
  end

endmodule

// ==== verilog/tile_mem_pkg.sv ====
// local data memory definitions for the compute tile
// one word per address, no byte enables
// opcode encoding is shared with the link flit format
package tile_mem_pkg;

  // packet opcodes carried on the network
  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_resp  = 2'd2
  } mem_op_e;

  // word address into the tile memory
  localparam int dmem_addr_width_lp = 8;

  // memory word width
  localparam int dmem_data_width_lp = 32;

  // number of words, fully covered by the address
  localparam int dmem_els_lp = 256;

endpackage

// ==== verilog/torus_noc_pkg.sv ====
// network definitions for a 4x4 torus of compute tiles
// single virtual channel, no dateline handling
// buffer depth must stay a power of two for the pointer wrap
package torus_noc_pkg;

  import tile_mem_pkg::*;

  localparam int x_cord_width_lp = 2;
  localparam int y_cord_width_lp = 2;

  // torus height for the y+1 wrap
  localparam int num_tiles_y_lp = 4;

  // input buffer depth and initial credit count
  localparam int link_fifo_els_lp    = 2;
  localparam int link_ptr_width_lp   = $clog2(link_fifo_els_lp);
  localparam int credit_cnt_width_lp = $clog2(link_fifo_els_lp + 1);

  // router ports with P as the local endpoint
  typedef enum logic [2:0] {
    dir_p = 3'd0,
    dir_w = 3'd1,
    dir_e = 3'd2,
    dir_n = 3'd3,
    dir_s = 3'd4
  } port_dir_e;

  localparam int num_dirs_lp = 5;

  typedef struct packed {
    mem_op_e                         opcode;
    logic [x_cord_width_lp-1:0]      dst_x;
    logic [y_cord_width_lp-1:0]      dst_y;
    logic [x_cord_width_lp-1:0]      src_x;
    logic [y_cord_width_lp-1:0]      src_y;
    logic [dmem_addr_width_lp-1:0]   addr;
    logic [dmem_data_width_lp-1:0]   data;
  } link_flit_s;

  typedef struct packed {
    logic       v;
    link_flit_s flit;
  } link_s;

endpackage

// ==== verilog/torus_route_ctrl.sv ====
`timescale 1ns/10ps
// route and credit control for the five-port tile router
// x first then y with flits moving only east and south
// each output grants one input per cycle in round robin order
// an output with no credits holds its requesters in their buffers
// the P input buffer lives here and the W to S buffers sit in the tile
module torus_route_ctrl (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic [torus_noc_pkg::x_cord_width_lp-1:0]  my_x_i,
  input  logic [torus_noc_pkg::y_cord_width_lp-1:0]  my_y_i,
  input  torus_noc_pkg::link_flit_s [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] head_i,
  input  logic [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] head_v_i,
  output logic [torus_noc_pkg::dir_s:torus_noc_pkg::dir_w] pop_o,
  output torus_noc_pkg::link_s [torus_noc_pkg::num_dirs_lp-1:0] out_o,
  input  logic [torus_noc_pkg::num_dirs_lp-1:0]      credit_i,
  input  torus_noc_pkg::link_s                       proc_link_i,
  output logic                                       proc_credit_o
);
  import torus_noc_pkg::*;

  link_flit_s                     p_head;
  logic                           p_head_v;
  link_flit_s [num_dirs_lp-1:0]   heads;
  logic [num_dirs_lp-1:0]         heads_v;
  logic [num_dirs_lp-1:0]         pop;
  port_dir_e                      route [num_dirs_lp];
  logic [num_dirs_lp-1:0]         grant_v;
  port_dir_e                      grant_idx [num_dirs_lp];
  port_dir_e                      last_r [num_dirs_lp];
  logic [credit_cnt_width_lp-1:0] credit_cnt_r [num_dirs_lp];

  // local injection buffer
  link_input_fifo p_fifo (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .link_i   (proc_link_i),
    .pop_i    (pop[dir_p]),
    .head_o   (p_head),
    .head_v_o (p_head_v),
    .credit_o (proc_credit_o)
  );

  assign heads   = {head_i, p_head};
  assign heads_v = {head_v_i, p_head_v};
  assign pop_o   = pop[dir_s:dir_w];

  // dimension-ordered route per input head
  always_comb begin
    for (int i = 0; i < num_dirs_lp; i++) begin
      if (heads[i].dst_x != my_x_i) begin
        route[i] = dir_e;
      end else if (heads[i].dst_y != my_y_i) begin
        route[i] = dir_s;
      end else begin
        route[i] = dir_p;
      end
    end
  end

  // round robin search starts after the last winner
  always_comb begin
    int idx;
    for (int o = 0; o < num_dirs_lp; o++) begin
      grant_v[o]   = 1'b0;
      grant_idx[o] = last_r[o];
      for (int k = 1; k <= num_dirs_lp; k++) begin
        idx = int'(last_r[o]) + k;
        if (idx >= num_dirs_lp) idx = idx - num_dirs_lp;
        if (!grant_v[o] && heads_v[idx] && (route[idx] == port_dir_e'(o))
            && (credit_cnt_r[o] != '0)) begin
          grant_v[o]   = 1'b1;
          grant_idx[o] = port_dir_e'(idx);
        end
      end
    end
  end

  // an input routes to one output only and so gets at most one grant
  always_comb begin
    pop = '0;
    for (int o = 0; o < num_dirs_lp; o++) begin
      if (grant_v[o]) pop[grant_idx[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_dirs_lp; o++) begin
      out_o[o].flit <= heads[grant_idx[o]];
      if (reset_i) begin
        out_o[o].v      <= 1'b0;
        last_r[o]       <= dir_s;
        credit_cnt_r[o] <= credit_cnt_width_lp'(link_fifo_els_lp);
      end else begin
        out_o[o].v <= grant_v[o];
        if (grant_v[o]) last_r[o] <= grant_idx[o];
        case ({grant_v[o], credit_i[o]})
          2'b10:   credit_cnt_r[o] <= credit_cnt_r[o] - 1'b1;
          2'b01:   credit_cnt_r[o] <= credit_cnt_r[o] + 1'b1;
          default: credit_cnt_r[o] <= credit_cnt_r[o];
        endcase
      end
    end
  end

endmodule
